// File: verilog/cart_settings.svh
// Cartridge loader settings
// Header offsets, download index codes, work-RAM size and the
// fill bytes used by the RAM clear

`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ====================
// ROM header layout
// ====================
// Copier header in front of the ROM image
`define CART_HEADER_SKIP 25'd512
// ROM size field of each info block, RAM size sits 2 bytes higher
`define CART_LOROM_INFO 25'h0007FD6
`define CART_HIROM_INFO 25'h000FFD6
`define CART_EXHIROM_INFO 25'h040FFD6
`define CART_SIZE_DEFAULT 4'hC

// Download index codes
`define CART_INDEX_CART 6'd0
`define CART_INDEX_CODE 8'hFF

// ====================
// Work-RAM clear
// ====================
`define CART_FILL_BITS 17
`define CART_FILL_A_HI 8'h66
`define CART_FILL_A_LO 8'h99
`define CART_FILL_B 8'h55
`define CART_FILL_C 8'hFF

`endif

// File: verilog/cart_pkg.sv
// Cartridge loader types
// Download words, cartridge description, cheat codes and the
// option encodings shared by the loader blocks

package cart_pkg;

	// One classified word of the host download stream
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
	} dl_word_t;

	// Cartridge description handed to the console core
	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	// Cheat code, fields in big endian byte order as loaded
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ROM header handling
	typedef enum logic [2:0] {
		hdr_auto,
		hdr_no_header,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} header_mode_e;

	// Initial work-RAM contents
	typedef enum logic [1:0] {
		fill_checker_66_99,
		fill_stripe_00_ff,
		fill_55,
		fill_ff
	} fill_mode_e;

	// Video region override
	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal,
		region_pal_alt
	} region_e;

endpackage

// File: verilog/download_decoder.sv
// Download decoder
// Registers the host download stream, sorts each word into cartridge
// or cheat data and flags the start of a cartridge download

`timescale 1ns/1ps
`include "cart_settings.svh"

module download_decoder (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               dl_active,
	input  logic [7:0]         dl_index,
	input  logic [24:0]        dl_addr,
	input  logic [15:0]        dl_data,
	input  logic               dl_wr,
	output cart_pkg::dl_word_t word,
	output logic               cart_wr,
	output logic               code_wr,
	output logic               cart_active,
	output logic               cart_start
);

	logic cart_index;
	logic code_index;
	logic cart_level;

	// Cartridge images use any index with the low six bits clear
	assign cart_index = (dl_index[5:0] == `CART_INDEX_CART);
	assign code_index = (dl_index == `CART_INDEX_CODE);
	assign cart_level = dl_active && cart_index;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_wr <= 1'b0;
			code_wr <= 1'b0;
			cart_active <= 1'b0;
			cart_start <= 1'b0;
		end else begin
			cart_wr <= dl_wr && cart_level;
			code_wr <= dl_wr && dl_active && code_index;
			cart_active <= cart_level;
			// High in the first cycle of cart_active
			cart_start <= cart_level && !cart_active;
		end
	end

	// Payload follows the strobe by one cycle
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			word.addr <= dl_addr;
			word.data <= dl_data;
		end
	end

	a_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(cart_wr && code_wr)
	) else $error("cart_wr and code_wr high together");

endmodule

// File: verilog/header_parser.sv
// ROM header parser
// Watches cartridge words for the header fields and derives the
// cartridge type, ROM and RAM address masks and the video region

`timescale 1ns/1ps
`include "cart_settings.svh"

module header_parser (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::dl_word_t     word,
	input  logic                   cart_wr,
	input  logic                   cart_active,
	input  cart_pkg::header_mode_e header_mode,
	input  cart_pkg::region_e      region,
	output cart_pkg::cart_info_t   cart_info
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [7:0]  rom_type;
	logic        header_region;
	logic        header_seen;
	logic        pal;
	logic        region_pal;
	logic        forced_mode;
	logic [24:0] info_addr;
	logic        rom_size_hit;
	logic        ram_size_hit;

	// ====================
	// Header address match
	// ====================
	always_comb begin
		forced_mode = 1'b1;
		case (header_mode)
			cart_pkg::hdr_lorom: info_addr = `CART_LOROM_INFO;
			cart_pkg::hdr_hirom: info_addr = `CART_HIROM_INFO;
			cart_pkg::hdr_exhirom: info_addr = `CART_EXHIROM_INFO;
			default: begin
				info_addr = '0;
				forced_mode = 1'b0;
			end
		endcase
	end

	// Info block sits behind the copier header in the image
	assign rom_size_hit = forced_mode && (word.addr == info_addr + `CART_HEADER_SKIP);
	assign ram_size_hit = forced_mode &&
		(word.addr == info_addr + `CART_HEADER_SKIP + 25'd2);

	// ====================
	// Size, type, region
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size <= 4'h0;
			ram_size <= 4'h0;
			rom_type <= 8'h00;
			header_region <= 1'b0;
			header_seen <= 1'b0;
			pal <= 1'b0;
		end else begin
			if (cart_wr) begin
				header_seen <= 1'b1;
				if (word.addr == 25'd0) begin
					rom_size <= `CART_SIZE_DEFAULT;
					ram_size <= 4'h0;
					// Auto mode trusts a nonzero size byte from the loader
					if (header_mode == cart_pkg::hdr_auto && word.data[7:0] != 8'h00) begin
						{ram_size, rom_size} <= word.data[7:0];
					end
					case (header_mode)
						cart_pkg::hdr_auto: rom_type <= word.data[15:8];
						cart_pkg::hdr_hirom: rom_type <= 8'd1;
						cart_pkg::hdr_exhirom: rom_type <= 8'd2;
						default: rom_type <= 8'd0;
					endcase
				end
				if (word.addr == 25'd2) begin
					header_region <= word.data[8];
				end
				if (rom_size_hit) begin
					rom_size <= word.data[11:8];
				end
				if (ram_size_hit) begin
					ram_size <= word.data[3:0];
				end
			end
			// Region is frozen while an image is coming in
			if (!cart_active) begin
				pal <= region_pal;
			end
		end
	end

	always_comb begin
		case (region)
			cart_pkg::region_auto: region_pal = header_region;
			cart_pkg::region_ntsc: region_pal = 1'b0;
			default: region_pal = 1'b1;
		endcase
	end

	// Masks straight from the size codes, 1 KB units
	always_comb begin
		cart_info.rom_type = rom_type;
		cart_info.rom_mask = header_seen ? (24'd1024 << rom_size) - 24'd1 : 24'd0;
		cart_info.ram_mask = (ram_size != 4'h0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
		cart_info.pal = pal;
	end

	a_pal_stable: assert property (
		@(posedge clk_sys) disable iff (reset)
		cart_active |=> $stable(cart_info.pal)
	) else $error("pal changed during cartridge download");

endmodule

// File: verilog/cheat_assembler.sv
// Cheat code assembler
// Collects eight 16-bit download words into one 128-bit cheat code
// and signals when the last half has arrived

`timescale 1ns/1ps

module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::dl_word_t    word,
	input  logic                  code_wr,
	input  logic                  cart_start,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                  cheat_valid,
	output logic                  cheat_clear
);

	logic code_done;

	// Low half first within each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word.addr[3:0])
				4'd0: cheat_code.flags[15:0] <= word.data;
				4'd2: cheat_code.flags[31:16] <= word.data;
				4'd4: cheat_code.address[15:0] <= word.data;
				4'd6: cheat_code.address[31:16] <= word.data;
				4'd8: cheat_code.compare[15:0] <= word.data;
				4'd10: cheat_code.compare[31:16] <= word.data;
				4'd12: cheat_code.replace[15:0] <= word.data;
				4'd14: cheat_code.replace[31:16] <= word.data;
				default: ;
			endcase
		end
	end

	// Valid one stage behind the final write, code already stable
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_done <= 1'b0;
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			code_done <= code_wr && (word.addr[3:0] == 4'd14);
			cheat_valid <= code_done;
			// New cheat list or new cartridge drops the stored codes
			cheat_clear <= (code_wr && word.addr == 25'd0) || cart_start;
		end
	end

	a_valid_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid
	) else $error("cheat_valid held for two cycles");

endmodule

// File: verilog/ram_clear_engine.sv
// Work-RAM clear engine
// Sweeps the whole work-RAM once per cartridge load, writing one
// byte per cycle from the selected power-on fill pattern

`timescale 1ns/1ps
`include "cart_settings.svh"

module ram_clear_engine (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       cart_start,
	input  cart_pkg::fill_mode_e       fill_mode,
	output logic [`CART_FILL_BITS-1:0] fill_addr,
	output logic [7:0]                 fill_data,
	output logic                       fill_we,
	output logic                       clear_active
);

	// ====================
	// Sweep counter
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clear_active <= 1'b0;
			fill_addr <= '0;
		end else if (cart_start) begin
			// Also restarts a sweep already in progress
			clear_active <= 1'b1;
			fill_addr <= '0;
		end else if (clear_active) begin
			fill_addr <= fill_addr + 1'b1;
			// Last address written, counter wraps back to zero
			if (&fill_addr) begin
				clear_active <= 1'b0;
			end
		end
	end

	assign fill_we = clear_active;

	// ====================
	// Fill patterns
	// ====================
	always_comb begin
		case (fill_mode)
			cart_pkg::fill_checker_66_99: begin
				fill_data = (fill_addr[8] ^ fill_addr[2]) ? `CART_FILL_A_HI : `CART_FILL_A_LO;
			end
			cart_pkg::fill_stripe_00_ff: begin
				fill_data = (fill_addr[9] ^ fill_addr[0]) ? `CART_FILL_C : 8'h00;
			end
			cart_pkg::fill_55: fill_data = `CART_FILL_B;
			default: fill_data = `CART_FILL_C;
		endcase
	end

	a_addr_idle: assert property (
		@(posedge clk_sys) disable iff (reset)
		!clear_active |-> (fill_addr == '0)
	) else $error("fill_addr nonzero while idle");

endmodule

// File: verilog/cart_loader.sv
// Cartridge loading front end
// Decodes the host download stream, parses the ROM header, builds
// cheat codes and clears work-RAM when a new cartridge arrives.
// core_hold keeps the console core stopped during load and clear

`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_active,
	input  logic [7:0]                 dl_index,
	input  logic [24:0]                dl_addr,
	input  logic [15:0]                dl_data,
	input  logic                       dl_wr,
	input  cart_pkg::header_mode_e     header_mode,
	input  cart_pkg::fill_mode_e       fill_mode,
	input  cart_pkg::region_e          region,
	output cart_pkg::cart_info_t       cart_info,
	output logic                       cart_active,
	output cart_pkg::cheat_code_t      cheat_code,
	output logic                       cheat_valid,
	output logic                       cheat_clear,
	output logic [`CART_FILL_BITS-1:0] fill_addr,
	output logic [7:0]                 fill_data,
	output logic                       fill_we,
	output logic                       clear_active,
	output logic                       core_hold
);

	cart_pkg::dl_word_t word;
	logic               cart_wr;
	logic               code_wr;
	logic               cart_start;

	// ====================
	// Stream decode
	// ====================
	download_decoder u_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wr       (dl_wr),
		.word        (word),
		.cart_wr     (cart_wr),
		.code_wr     (code_wr),
		.cart_active (cart_active),
		.cart_start  (cart_start)
	);

	header_parser u_parser (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.word        (word),
		.cart_wr     (cart_wr),
		.cart_active (cart_active),
		.header_mode (header_mode),
		.region      (region),
		.cart_info   (cart_info)
	);

	cheat_assembler u_cheats (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.word        (word),
		.code_wr     (code_wr),
		.cart_start  (cart_start),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	ram_clear_engine u_clear (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_start   (cart_start),
		.fill_mode    (fill_mode),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_we      (fill_we),
		.clear_active (clear_active)
	);

	// Core stays held until both download and clear are done
	assign core_hold = cart_active | clear_active;

endmodule

// File: bench/tb_clock.sv
// Testbench clock and reset
// 4 ns clk_sys, reset held high for the first cycles and
// released on a falling edge

`timescale 1ns/1ps

module tb_clock #(
	parameter int reset_cycles = 16
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

	always #2 clk_sys = ~clk_sys;

endmodule

// File: bench/cart_loader_tb.sv
// Cartridge loader testbench
// Drives host download streams into the loader and checks header
// decode, region, cheat assembly and the work-RAM clear through
// concurrent assertions against its own reference values

`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_loader_tb;

	localparam int clear_len = 1 << `CART_FILL_BITS;
	// Four full clears plus the short header, region and cheat runs
	localparam int max_cycles = 4 * clear_len + 75712;
	localparam logic [`CART_FILL_BITS-1:0] addr_one = {{(`CART_FILL_BITS-1){1'b0}}, 1'b1};

	logic                       clk_sys;
	logic                       reset;
	logic                       dl_active;
	logic [7:0]                 dl_index;
	logic [24:0]                dl_addr;
	logic [15:0]                dl_data;
	logic                       dl_wr;
	cart_pkg::header_mode_e     header_mode;
	cart_pkg::fill_mode_e       fill_mode;
	cart_pkg::region_e          region;
	cart_pkg::cart_info_t       cart_info;
	logic                       cart_active;
	cart_pkg::cheat_code_t      cheat_code;
	logic                       cheat_valid;
	logic                       cheat_clear;
	logic [`CART_FILL_BITS-1:0] fill_addr;
	logic [7:0]                 fill_data;
	logic                       fill_we;
	logic                       clear_active;
	logic                       core_hold;

	// Reference state
	cart_pkg::cart_info_t  exp_info;
	cart_pkg::cheat_code_t exp_code;
	logic                  info_check;
	logic                  hdr_bit;
	logic                  cart_in;
	logic                  cart_in_q;
	logic                  start_q;
	logic                  clear_ref;
	logic                  code_last;
	logic                  code_zero;
	logic [24:0]           info_addrs [3];
	int                    clear_left;
	int                    fill_count;
	int                    seed;
	int                    cycles = 0;
	int                    errors = 0;
	int                    errors_before = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;

	tb_clock u_clock (.clk_sys(clk_sys), .reset(reset));

	cart_loader dut (.*);

	// ====================
	// Reference model
	// ====================
	assign cart_in = dl_active && (dl_index[5:0] == 6'd0);
	assign code_last = dl_wr && dl_active && (dl_index == 8'hFF) && (dl_addr[3:0] == 4'd14);
	assign code_zero = dl_wr && dl_active && (dl_index == 8'hFF) && (dl_addr == 25'd0);

	always @(posedge clk_sys) begin
		if (reset) begin
			cart_in_q <= 1'b0;
			start_q <= 1'b0;
			fill_count <= 0;
			clear_ref <= 1'b0;
			clear_left <= 0;
		end else begin
			cart_in_q <= cart_in;
			start_q <= cart_in && !cart_in_q;
			if (start_q) begin
				fill_count <= 0;
				clear_ref <= 1'b1;
				clear_left <= clear_len;
			end else begin
				if (fill_we) begin
					fill_count <= fill_count + 1;
				end
				// Sweep lasts one cycle per work-RAM byte
				if (clear_ref) begin
					clear_left <= clear_left - 1;
					if (clear_left == 1) begin
						clear_ref <= 1'b0;
					end
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout: the run did not finish within %0d clock cycles", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Mask for a size code in 1 KB units kept to 24 bits
	function automatic logic [23:0] size_mask(input logic [3:0] size);
		logic [31:0] full;
		full = (32'd1024 << size) - 32'd1;
		return full[23:0];
	endfunction

	function automatic cart_pkg::cart_info_t make_info(input logic [7:0] rom_type,
			input logic [3:0] rom_size, input logic [3:0] ram_size, input logic pal);
		cart_pkg::cart_info_t info;
		info.rom_type = rom_type;
		info.rom_mask = size_mask(rom_size);
		info.ram_mask = (ram_size == 4'h0) ? 24'h0 : size_mask(ram_size);
		info.pal = pal;
		return info;
	endfunction

	function automatic logic pal_for(input cart_pkg::region_e r, input logic header_bit);
		if (r == cart_pkg::region_auto) begin
			return header_bit;
		end
		return (r != cart_pkg::region_ntsc);
	endfunction

	function automatic logic [7:0] fill_byte(input cart_pkg::fill_mode_e mode,
			input logic [`CART_FILL_BITS-1:0] addr);
		case (mode)
			cart_pkg::fill_checker_66_99: return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::fill_stripe_00_ff: return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::fill_55: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// ====================
	// Assertions
	// ====================
	a_reset_state: assert property (@(posedge clk_sys) $fell(reset) |->
		(!cheat_valid && !cheat_clear && !fill_we && !clear_active && !cart_active &&
		!core_hold && cart_info == '0 && fill_addr == '0))
	else begin
		errors++;
		$display("error %0t: outputs not idle after reset", $time);
	end

	a_hold: assert property (@(posedge clk_sys) disable iff (reset)
		cart_active == cart_in_q && clear_active == clear_ref && fill_we == clear_ref &&
		core_hold == (cart_in_q || clear_ref))
	else begin
		errors++;
		$display("error %0t: cart_active %b clear_active %b fill_we %b core_hold %b",
			$time, cart_active, clear_active, fill_we, core_hold);
	end

	a_info: assert property (@(posedge clk_sys) disable iff (reset)
		info_check |-> cart_info == exp_info)
	else begin
		errors++;
		$display("error %0t: cart_info %h, expected %h", $time, cart_info, exp_info);
	end

	a_valid: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid == $past(code_last, 3))
	else begin
		errors++;
		$display("error %0t: cheat_valid %b at the wrong time", $time, cheat_valid);
	end

	a_code: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |-> cheat_code == exp_code)
	else begin
		errors++;
		$display("error %0t: cheat_code %h, expected %h", $time, cheat_code, exp_code);
	end

	a_clear_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_clear == ($past(code_zero, 2) || $past(start_q)))
	else begin
		errors++;
		$display("error %0t: cheat_clear %b at the wrong time", $time, cheat_clear);
	end

	a_start: assert property (@(posedge clk_sys) disable iff (reset)
		$past(start_q) |-> (cheat_clear && clear_active && fill_addr == '0))
	else begin
		errors++;
		$display("error %0t: cart start gave clear %b active %b addr %h", $time,
			cheat_clear, clear_active, fill_addr);
	end

	a_fill_step: assert property (@(posedge clk_sys) disable iff (reset)
		(clear_active && $past(clear_active) && !$past(start_q)) |->
		fill_addr == $past(fill_addr) + addr_one)
	else begin
		errors++;
		$display("error %0t: fill_addr %h did not step by one", $time, fill_addr);
	end

	a_fill_data: assert property (@(posedge clk_sys) disable iff (reset)
		fill_we |-> fill_data == fill_byte(fill_mode, fill_addr))
	else begin
		errors++;
		$display("error %0t: fill_data %h at %h, expected %h", $time, fill_data,
			fill_addr, fill_byte(fill_mode, fill_addr));
	end

	a_fill_count: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(clear_active) |-> fill_count == clear_len)
	else begin
		errors++;
		$display("error %0t: clear wrote %0d bytes, expected %0d", $time, fill_count,
			clear_len);
	end

	// ====================
	// Stimulus
	// ====================
	task automatic start_download(input logic [7:0] index);
		dl_active = 1'b1;
		dl_index = index;
		@(negedge clk_sys);
	endtask

	// pal settles two cycles after the download drops
	task automatic end_download();
		info_check = 1'b0;
		dl_active = 1'b0;
		repeat (2) @(negedge clk_sys);
		exp_info.pal = pal_for(region, hdr_bit);
		info_check = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic cart_word(input logic [24:0] addr, input logic [15:0] data,
			input cart_pkg::cart_info_t exp);
		info_check = 1'b0;
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
		exp_info = exp;
		info_check = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic code_word(input logic [24:0] addr, input logic [15:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic set_region(input cart_pkg::region_e r);
		info_check = 1'b0;
		region = r;
		@(negedge clk_sys);
		exp_info.pal = pal_for(r, hdr_bit);
		info_check = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic auto_header_run();
		logic [15:0] data;
		logic [3:0]  rom_size;
		logic [3:0]  ram_size;
		header_mode = cart_pkg::hdr_auto;
		start_download(8'h00);
		data = 16'($random(seed));
		{ram_size, rom_size} = (data[7:0] != 8'h00) ? data[7:0] : 8'h0C;
		cart_word(25'd0, data, make_info(data[15:8], rom_size, ram_size, exp_info.pal));
		data = {8'($random(seed)), 8'h00};
		cart_word(25'd0, data, make_info(data[15:8], 4'hC, 4'h0, exp_info.pal));
		end_download();
	endtask

	task automatic forced_mode_run(input cart_pkg::header_mode_e mode, input int sel);
		logic [7:0] rom_type;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
		int         i;
		rom_type = 8'(sel);
		header_mode = mode;
		start_download((sel == 1) ? 8'h40 : 8'h00);
		cart_word(25'd0, 16'($random(seed)), make_info(rom_type, 4'hC, 4'h0, exp_info.pal));
		rom_size = 4'($random(seed));
		ram_size = 4'($random(seed));
		cart_word(info_addrs[sel], {4'($random(seed)), rom_size, 8'($random(seed))},
			make_info(rom_type, rom_size, 4'h0, exp_info.pal));
		cart_word(info_addrs[sel] + 25'd2, {12'($random(seed)), ram_size},
			make_info(rom_type, rom_size, ram_size, exp_info.pal));
		// Info blocks of the other layouts are plain ROM data here
		for (i = 0; i < 3; i++) begin
			if (i != sel) begin
				cart_word(info_addrs[i], 16'($random(seed)), exp_info);
				cart_word(info_addrs[i] + 25'd2, 16'($random(seed)), exp_info);
			end
		end
		end_download();
	endtask

	task automatic region_run();
		int i;
		header_mode = cart_pkg::hdr_auto;
		for (i = 0; i < 2; i++) begin
			start_download(8'h00);
			hdr_bit = (i == 0) ? 1'($random(seed)) : !hdr_bit;
			cart_word(25'd2, {7'($random(seed)), hdr_bit, 8'($random(seed))}, exp_info);
			end_download();
		end
		set_region(cart_pkg::region_ntsc);
		set_region(cart_pkg::region_pal);
		set_region(cart_pkg::region_pal_alt);
		set_region(cart_pkg::region_auto);
	endtask

	task automatic cheat_run();
		logic [15:0] w [8];
		int          i;
		int          n;
		start_download(8'hFF);
		code_word(25'd0, 16'($random(seed)));
		// Seven halves never complete a code
		for (i = 0; i < 7; i++) begin
			code_word(25'd16 + 25'(2 * i), 16'($random(seed)));
		end
		repeat (4) @(negedge clk_sys);
		for (n = 0; n < 2; n++) begin
			for (i = 0; i < 8; i++) begin
				w[i] = 16'($random(seed));
			end
			exp_code = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
			for (i = 0; i < 8; i++) begin
				code_word(25'd32 + 25'(16 * n + 2 * i), w[i]);
			end
			repeat (4) @(negedge clk_sys);
		end
		end_download();
	endtask

	task automatic clear_run();
		int m;
		for (m = 0; m < 4; m++) begin
			fill_mode = cart_pkg::fill_mode_e'(m);
			start_download(8'h00);
			repeat (8) @(negedge clk_sys);
			end_download();
			while (core_hold) begin
				@(negedge clk_sys);
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end else begin
			$display("test %s: ok", name);
		end
		errors_before = errors;
	endtask

	initial begin
		seed = 32'h47393a1f;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_addr = 25'd0;
		dl_data = 16'h0000;
		dl_wr = 1'b0;
		header_mode = cart_pkg::hdr_auto;
		fill_mode = cart_pkg::fill_checker_66_99;
		region = cart_pkg::region_auto;
		exp_info = '0;
		exp_code = '0;
		info_check = 1'b0;
		hdr_bit = 1'b0;
		info_addrs[0] = `CART_LOROM_INFO + `CART_HEADER_SKIP;
		info_addrs[1] = `CART_HIROM_INFO + `CART_HEADER_SKIP;
		info_addrs[2] = `CART_EXHIROM_INFO + `CART_HEADER_SKIP;
		@(negedge reset);
		repeat (2) @(negedge clk_sys);
		finish_test("reset");
		auto_header_run();
		finish_test("auto header");
		forced_mode_run(cart_pkg::hdr_lorom, 0);
		forced_mode_run(cart_pkg::hdr_hirom, 1);
		forced_mode_run(cart_pkg::hdr_exhirom, 2);
		finish_test("forced modes");
		region_run();
		finish_test("region");
		cheat_run();
		finish_test("cheats");
		clear_run();
		finish_test("ram clear");
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/cart_pkg.sv
verilog/download_decoder.sv
verilog/header_parser.sv
verilog/cheat_assembler.sv
verilog/ram_clear_engine.sv
verilog/cart_loader.sv
bench/tb_clock.sv
bench/cart_loader_tb.sv

// File: Makefile
# Verilator build and run of the cartridge loader testbench

VERILATOR ?= verilator
TOP ?= cart_loader_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "make test    build the testbench with Verilator and run it"
	@echo "make clean   remove the build directory"
	@echo "make help    show this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
